/* nanorv32_defs.svh */
// Fixed chip widths and a 64K peripheral window, word offsets in address bits 3 to 2 only
`ifndef NANORV32_DEFS_SVH
`define NANORV32_DEFS_SVH

`define NRV_DATA_W        32     // Bus data word
`define NRV_ADDR_W        16     // One 64K window
`define NRV_GPIO_W        16     // GPIO pin count
`define NRV_IRQ_W         8      // Interrupt sources, bit 0 GPIO, bit 1 external
`define NRV_SYNC_STAGES   2      // Flops per synchronizer, at least 2

// Region field of the address
`define NRV_REGION_MSB    15
`define NRV_REGION_LSB    12
`define NRV_REGION_GPIO    4'd0
`define NRV_REGION_INTC    4'd1
`define NRV_REGION_CPUCTRL 4'd2

// Word offset field inside a region
`define NRV_OFS_MSB       3
`define NRV_OFS_LSB       2
`define NRV_GPIO_OUT      2'd0   // Output data
`define NRV_GPIO_DIR      2'd1   // Output enables
`define NRV_GPIO_IN       2'd2   // Synchronized pins, read only
`define NRV_GPIO_IRQ      2'd3   // Mask in [31:16], pending in [15:0]
`define NRV_INTC_EN       2'd0
`define NRV_INTC_PEND     2'd1
`define NRV_CPUCTRL_CTRL  2'd0   // Bit 0 holds the CPU in reset

`endif

/* nanorv32_pkg.sv */
// Bus and register-access types for the peripheral side; byte selects are carried but unused
`include "nanorv32_defs.svh"

package nanorv32_pkg;

   // Master side of Wishbone classic
   typedef struct packed {
      logic                    cyc;
      logic                    stb;
      logic                    we;
      logic [`NRV_ADDR_W-1:0]  adr;
      logic [`NRV_DATA_W-1:0]  dat;
      logic [`NRV_DATA_W/8-1:0] sel;   // Ignored, full words only
   } wb_req_t;

   // Slave side, dat valid only with ack
   typedef struct packed {
      logic                    ack;
      logic [`NRV_DATA_W-1:0]  dat;
   } wb_rsp_t;

   // Decoded access, one cycle wide
   typedef struct packed {
      logic                    we;      // Write strobe, accept cycle only
      logic [1:0]              ofs;     // Word offset in region
      logic [`NRV_DATA_W-1:0]  wdata;
   } reg_access_t;

   // One-hot target of the access
   typedef struct packed {
      logic                    gpio;
      logic                    intc;
      logic                    cpuctrl;
   } periph_sel_t;

endpackage

/* periph_decode.sv */
// Wishbone classic slave, full-word accesses only, one access per two cycles, unmapped reads zero
`timescale 1ns/100ps
`include "nanorv32_defs.svh"

module periph_decode (
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  nanorv32_pkg::wb_req_t      wb_req_i,
   input  logic [`NRV_DATA_W-1:0]     gpio_rdata_i,
   input  logic [`NRV_DATA_W-1:0]     intc_rdata_i,
   input  logic [`NRV_DATA_W-1:0]     cpuctrl_rdata_i,
   output nanorv32_pkg::wb_rsp_t      wb_rsp_o,
   output nanorv32_pkg::reg_access_t  reg_acc_o,
   output nanorv32_pkg::periph_sel_t  periph_sel_o
);

   logic                    accept;       // Request taken this cycle
   logic [3:0]              region;
   logic [`NRV_DATA_W-1:0]  rdata_mux;
   logic                    ack_q;
   logic [`NRV_DATA_W-1:0]  rdata_q;

   assign accept = wb_req_i.cyc & wb_req_i.stb & ~ack_q;   // No accept in ack cycle
   assign region = wb_req_i.adr[`NRV_REGION_MSB:`NRV_REGION_LSB];

   // Region to one-hot, only while accepting
   always_comb begin
      periph_sel_o = '0;
      if (accept) begin
         case (region)
            `NRV_REGION_GPIO:    periph_sel_o.gpio    = 1'b1;
            `NRV_REGION_INTC:    periph_sel_o.intc    = 1'b1;
            `NRV_REGION_CPUCTRL: periph_sel_o.cpuctrl = 1'b1;
            default:             periph_sel_o         = '0;   // Unmapped
         endcase
      end
   end

   assign reg_acc_o.we    = accept & wb_req_i.we;                      // Strobe
   assign reg_acc_o.ofs   = wb_req_i.adr[`NRV_OFS_MSB:`NRV_OFS_LSB];
   assign reg_acc_o.wdata = wb_req_i.dat;

   always_comb begin
      rdata_mux = '0;                                  // Unmapped reads zero
      if (periph_sel_o.gpio)    rdata_mux = gpio_rdata_i;
      if (periph_sel_o.intc)    rdata_mux = intc_rdata_i;
      if (periph_sel_o.cpuctrl) rdata_mux = cpuctrl_rdata_i;
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= accept;                              // One cycle after accept
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         rdata_q <= rdata_mux;                         // Held until next access
      end
   end

   assign wb_rsp_o.ack = ack_q;
   assign wb_rsp_o.dat = rdata_q;

   // At most one peripheral sees the access
   a_sel_onehot : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(periph_sel_o));

   // Held stb must not produce back-to-back acks
   a_ack_single : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      ack_q |=> !ack_q);

endmodule

/* gpio_regs.sv */
// GPIO with rising-edge interrupts; IRQ offset write sets mask from [31:16], clears pending with 1s in [15:0]
`timescale 1ns/100ps
`include "nanorv32_defs.svh"

module gpio_regs (
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  nanorv32_pkg::reg_access_t  reg_acc_i,
   input  logic                       sel_i,
   input  logic [`NRV_GPIO_W-1:0]     gpio_in_i,
   output logic [`NRV_DATA_W-1:0]     rdata_o,
   output logic [`NRV_GPIO_W-1:0]     gpio_out_o,
   output logic [`NRV_GPIO_W-1:0]     gpio_oe_o,
   output logic                       gpio_irq_o
);

   logic                                         wr;
   logic [`NRV_SYNC_STAGES-1:0][`NRV_GPIO_W-1:0] sync_q;    // [0] is first stage
   logic [`NRV_GPIO_W-1:0]                       in_q;
   logic [`NRV_GPIO_W-1:0]                       out_q;
   logic [`NRV_GPIO_W-1:0]                       dir_q;
   logic [`NRV_GPIO_W-1:0]                       mask_q;
   logic [`NRV_GPIO_W-1:0]                       pend_q;
   logic [`NRV_GPIO_W-1:0]                       rise;
   logic [`NRV_GPIO_W-1:0]                       clr;

   assign wr   = sel_i & reg_acc_i.we;
   assign rise = sync_q[`NRV_SYNC_STAGES-1] & ~in_q & mask_q;    // Masked rising edges
   assign clr  = (wr && reg_acc_i.ofs == `NRV_GPIO_IRQ) ?
                 reg_acc_i.wdata[`NRV_GPIO_W-1:0] : '0;          // Write 1 to clear

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sync_q <= '0;
         in_q   <= '0;
         out_q  <= '0;
         dir_q  <= '0;                                   // All pins inputs
         mask_q <= '0;
         pend_q <= '0;
      end else begin
         sync_q <= {sync_q[`NRV_SYNC_STAGES-2:0], gpio_in_i};
         in_q   <= sync_q[`NRV_SYNC_STAGES-1];
         pend_q <= (pend_q & ~clr) | rise;              // New edge beats clear
         if (wr) begin
            case (reg_acc_i.ofs)
               `NRV_GPIO_OUT: out_q  <= reg_acc_i.wdata[`NRV_GPIO_W-1:0];
               `NRV_GPIO_DIR: dir_q  <= reg_acc_i.wdata[`NRV_GPIO_W-1:0];
               `NRV_GPIO_IRQ: mask_q <= reg_acc_i.wdata[`NRV_DATA_W-1:`NRV_GPIO_W];
               default:       mask_q <= mask_q;          // Input register read only
            endcase
         end
      end
   end

   // Read word for the decoder
   always_comb begin
      rdata_o = '0;
      case (reg_acc_i.ofs)
         `NRV_GPIO_OUT: rdata_o[`NRV_GPIO_W-1:0] = out_q;
         `NRV_GPIO_DIR: rdata_o[`NRV_GPIO_W-1:0] = dir_q;
         `NRV_GPIO_IN:  rdata_o[`NRV_GPIO_W-1:0] = in_q;
         default:       rdata_o[`NRV_GPIO_W-1:0] = pend_q;    // Pending only
      endcase
   end

   assign gpio_out_o = out_q;
   assign gpio_oe_o  = dir_q;
   assign gpio_irq_o = |pend_q;                          // Level to the controller

endmodule

/* nanorv32_intc.sv */
// Interrupt controller; source 0 GPIO level, source 1 external edge latched, sources 7 to 2 tied low
`timescale 1ns/100ps
`include "nanorv32_defs.svh"

module nanorv32_intc (
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  nanorv32_pkg::reg_access_t  reg_acc_i,
   input  logic                       sel_i,
   input  logic                       gpio_irq_i,
   input  logic                       irq_ext_i,
   output logic [`NRV_DATA_W-1:0]     rdata_o,
   output logic                       cpu_irq_o
);

   logic                          wr;
   logic [`NRV_SYNC_STAGES-1:0]   ext_sync_q;    // External pin synchronizer
   logic                          ext_d;         // Last synchronized value
   logic                          ext_pend_q;
   logic [`NRV_IRQ_W-1:0]         en_q;
   logic [`NRV_IRQ_W-1:0]         sources;
   logic                          cpu_irq_q;

   assign wr      = sel_i & reg_acc_i.we;
   assign sources = {{(`NRV_IRQ_W-2){1'b0}}, ext_pend_q, gpio_irq_i};

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ext_sync_q <= '0;
         ext_d      <= 1'b0;
         ext_pend_q <= 1'b0;
         en_q       <= '0;
         cpu_irq_q  <= 1'b0;
      end else begin
         ext_sync_q <= {ext_sync_q[`NRV_SYNC_STAGES-2:0], irq_ext_i};
         ext_d      <= ext_sync_q[`NRV_SYNC_STAGES-1];
         if (ext_sync_q[`NRV_SYNC_STAGES-1] & ~ext_d) begin
            ext_pend_q <= 1'b1;                          // Edge wins over clear
         end else if (wr && reg_acc_i.ofs == `NRV_INTC_PEND && reg_acc_i.wdata[1]) begin
            ext_pend_q <= 1'b0;
         end
         if (wr && reg_acc_i.ofs == `NRV_INTC_EN) begin
            en_q <= reg_acc_i.wdata[`NRV_IRQ_W-1:0];
         end
         cpu_irq_q <= |(sources & en_q);                 // Registered to the core
      end
   end

   always_comb begin
      rdata_o = '0;
      case (reg_acc_i.ofs)
         `NRV_INTC_EN:   rdata_o[`NRV_IRQ_W-1:0] = en_q;
         `NRV_INTC_PEND: rdata_o[`NRV_IRQ_W-1:0] = sources;   // Raw source vector
         default:        rdata_o = '0;
      endcase
   end

   assign cpu_irq_o = cpu_irq_q;

   // All sources disabled means no request one cycle later
   a_irq_needs_en : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (en_q == '0) |=> !cpu_irq_q);

endmodule

/* cpuctrl.sv */
// CPU control register; bit 0 holds the core in reset, release takes two clock edges after clearing
`timescale 1ns/100ps
`include "nanorv32_defs.svh"

module cpuctrl (
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  nanorv32_pkg::reg_access_t  reg_acc_i,
   input  logic                       sel_i,
   output logic [`NRV_DATA_W-1:0]     rdata_o,
   output logic                       cpu_rst_n_o
);

   logic                          hold_q;        // CTRL bit 0
   logic                          rst_async_n;
   logic [`NRV_SYNC_STAGES-1:0]   rst_sync_q;    // Shifts ones in after release

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         hold_q <= 1'b0;                             // Core runs after chip reset
      end else if (sel_i && reg_acc_i.we && reg_acc_i.ofs == `NRV_CPUCTRL_CTRL) begin
         hold_q <= reg_acc_i.wdata[0];
      end
   end

   // Assert asynchronously, release synchronously
   assign rst_async_n = arst_n_i & ~hold_q;

   always_ff @(posedge clk_i or negedge rst_async_n) begin
      if (!rst_async_n) begin
         rst_sync_q <= '0;
      end else begin
         rst_sync_q <= {rst_sync_q[`NRV_SYNC_STAGES-2:0], 1'b1};
      end
   end

   assign cpu_rst_n_o = rst_sync_q[`NRV_SYNC_STAGES-1];

   always_comb begin
      rdata_o = '0;
      if (reg_acc_i.ofs == `NRV_CPUCTRL_CTRL) begin
         rdata_o[0] = hold_q;
      end
   end

   // Core must stay in reset while held
   a_hold_rst : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      hold_q |-> !cpu_rst_n_o);

endmodule

/* nanorv32_periph.sv */
// Peripheral side of the chip on one Wishbone classic slave port, single clock, full-word accesses
`timescale 1ns/100ps
`include "nanorv32_defs.svh"

module nanorv32_periph (
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  nanorv32_pkg::wb_req_t      wb_req_i,
   input  logic [`NRV_GPIO_W-1:0]     gpio_in_i,
   input  logic                       irq_ext_i,
   output nanorv32_pkg::wb_rsp_t      wb_rsp_o,
   output logic [`NRV_GPIO_W-1:0]     gpio_out_o,
   output logic [`NRV_GPIO_W-1:0]     gpio_oe_o,
   output logic                       cpu_irq_o,
   output logic                       cpu_rst_n_o
);

   nanorv32_pkg::reg_access_t  reg_acc;        // Shared by all peripherals
   nanorv32_pkg::periph_sel_t  periph_sel;
   logic [`NRV_DATA_W-1:0]     gpio_rdata;
   logic [`NRV_DATA_W-1:0]     intc_rdata;
   logic [`NRV_DATA_W-1:0]     cpuctrl_rdata;
   logic                       gpio_irq;       // GPIO to controller source 0

   periph_decode u_decode (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .wb_req_i        (wb_req_i),
      .gpio_rdata_i    (gpio_rdata),
      .intc_rdata_i    (intc_rdata),
      .cpuctrl_rdata_i (cpuctrl_rdata),
      .wb_rsp_o        (wb_rsp_o),
      .reg_acc_o       (reg_acc),
      .periph_sel_o    (periph_sel)
   );

   gpio_regs u_gpio (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .reg_acc_i  (reg_acc),
      .sel_i      (periph_sel.gpio),
      .gpio_in_i  (gpio_in_i),
      .rdata_o    (gpio_rdata),
      .gpio_out_o (gpio_out_o),
      .gpio_oe_o  (gpio_oe_o),
      .gpio_irq_o (gpio_irq)
   );

   nanorv32_intc u_intc (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .reg_acc_i  (reg_acc),
      .sel_i      (periph_sel.intc),
      .gpio_irq_i (gpio_irq),
      .irq_ext_i  (irq_ext_i),
      .rdata_o    (intc_rdata),
      .cpu_irq_o  (cpu_irq_o)
   );

   cpuctrl u_cpuctrl (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .reg_acc_i   (reg_acc),
      .sel_i       (periph_sel.cpuctrl),
      .rdata_o     (cpuctrl_rdata),
      .cpu_rst_n_o (cpu_rst_n_o)
   );

endmodule

/* tb_nanorv32_periph.sv */
// Full-word Wishbone accesses only and IRQ and reset wait limits sized for 2-flop synchronizers
`timescale 1ns/100ps
`include "nanorv32_defs.svh"

module tb_nanorv32_periph;

   typedef enum logic [2:0] {
      OP_WR, OP_RD, OP_PINS, OP_EXT, OP_IDLE, OP_PORTS, OP_IRQ, OP_RST
   } op_e;

   typedef struct packed {
      logic [2:0]             test;
      op_e                    op;
      logic [`NRV_ADDR_W-1:0] adr;
      logic [`NRV_DATA_W-1:0] wdat;    // Cycle count or wait limit for non-bus ops
      logic [`NRV_GPIO_W-1:0] pins;
      logic [`NRV_DATA_W-1:0] exp;     // {oe, out} for port checks
   } entry_t;

   logic                    clk_i;
   logic                    arst_n_i;
   nanorv32_pkg::wb_req_t   wb_req_i;
   nanorv32_pkg::wb_rsp_t   wb_rsp_o;
   logic [`NRV_GPIO_W-1:0]  gpio_in_i;
   logic                    irq_ext_i;
   logic [`NRV_GPIO_W-1:0]  gpio_out_o;
   logic [`NRV_GPIO_W-1:0]  gpio_oe_o;
   logic                    cpu_irq_o;
   logic                    cpu_rst_n_o;
   logic [31:0]             lfsr_q;
   entry_t                  stim_q[$];     // Stimulus and expected values
   int                      errors;
   int                      checks;
   int                      tests;

   nanorv32_periph nanorv32_periph_i (.*);

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;                     // 100 MHz
   end

   // Watchdog
   initial begin
      #1;
      repeat (stim_q.size() * 20) @(posedge clk_i);
      $display("timeout, the run did not end within %0d cycles", stim_q.size() * 20);
      $display("Errors found");
      $finish;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
   endfunction

   task automatic draw_bits(input int nbits, output logic [31:0] val);
      int b;
      val = '0;
      for (b = 0; b < nbits; b++) begin
         lfsr_q = lfsr_next(lfsr_q);                 // One step per bit
         val    = {val[30:0], lfsr_q[0]};
      end
   endtask

   task automatic add_entry(input logic [2:0] test, input op_e op, input logic [15:0] adr,
                            input logic [31:0] wdat, input logic [15:0] pins,
                            input logic [31:0] exp);
      stim_q.push_back({test, op, adr, wdat, pins, exp});
   endtask

   task automatic check_word(input logic [`NRV_DATA_W-1:0] got, exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_pins(input logic [`NRV_GPIO_W-1:0] got, exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input logic got, exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // One Wishbone classic cycle, ack counted in clock edges
   task automatic bus_access(input logic we, input logic [`NRV_ADDR_W-1:0] adr,
                             input logic [`NRV_DATA_W-1:0] wdat,
                             output logic [`NRV_DATA_W-1:0] rdat);
      int n;
      n = 0;
      @(posedge clk_i);
      wb_req_i <= {1'b1, 1'b1, we, adr, wdat, 4'hf};  // cyc stb we adr dat sel
      do begin
         @(negedge clk_i);
         n++;
      end while (!wb_rsp_o.ack && n < 8);
      if (!wb_rsp_o.ack) begin
         errors++;
         $display("no acknowledge for address %h within 8 cycles", adr);
      end
      check_word(n - 1, 1, "ack delay in cycles");
      rdat = wb_rsp_o.dat;                            // Valid with ack only
      @(posedge clk_i);
      wb_req_i <= '0;
      @(negedge clk_i);
      check_flag(wb_rsp_o.ack, 1'b0, "ack after its one cycle");
   endtask

   initial begin
      entry_t                 e;
      logic [`NRV_DATA_W-1:0] rd;
      logic [31:0]            rnd [5];
      int                     n;
      int                     errs_at;
      lfsr_q    = 32'h8a97_7dc1;
      errors    = 0;
      checks    = 0;
      tests     = 0;
      errs_at   = 0;
      arst_n_i  = 1'b0;
      wb_req_i  = '0;
      gpio_in_i = '0;
      irq_ext_i = 1'b0;
      draw_bits(32, rnd[0]);                          // GPIO out
      draw_bits(32, rnd[1]);                          // GPIO dir
      draw_bits(16, rnd[2]);                          // Input pins
      draw_bits(4, rnd[3]);                           // Interrupt pin index
      draw_bits(32, rnd[4]);                          // Control word
      add_entry(1, OP_PORTS, 0, 0, 0, 0);             // All outputs low
      add_entry(1, OP_RST, 0, 3, 0, 1);               // Core leaves reset
      add_entry(1, OP_RD, 16'h2000, 0, 0, 0);
      add_entry(2, OP_WR, 16'h0000, rnd[0], 0, 0);
      add_entry(2, OP_WR, 16'h0004, rnd[1], 0, 0);
      add_entry(2, OP_RD, 16'h0000, 0, 0, {16'h0, rnd[0][15:0]});
      add_entry(2, OP_RD, 16'h0004, 0, 0, {16'h0, rnd[1][15:0]});
      add_entry(2, OP_PORTS, 0, 0, 0, {rnd[1][15:0], rnd[0][15:0]});
      add_entry(3, OP_PINS, 0, 0, rnd[2][15:0], 0);
      add_entry(3, OP_RD, 16'h0008, 0, 0, {16'h0, rnd[2][15:0]});
      add_entry(3, OP_RD, 16'hf004, 0, 0, 0);         // Unmapped region
      add_entry(4, OP_PINS, 0, 0, 0, 0);
      add_entry(4, OP_WR, 16'h1000, 1, 0, 0);         // GPIO source on
      add_entry(4, OP_WR, 16'h000c, 32'h1_0000 << rnd[3][3:0], 0, 0);
      add_entry(4, OP_PINS, 0, 0, 16'd1 << rnd[3][3:0], 0);
      add_entry(4, OP_IRQ, 0, 2, 0, 1);               // Six cycles after the pin edge
      add_entry(4, OP_RD, 16'h000c, 0, 0, 32'd1 << rnd[3][3:0]);
      add_entry(4, OP_WR, 16'h000c, 32'h1_0001 << rnd[3][3:0], 0, 0);  // Mask kept, pending cleared
      add_entry(4, OP_IRQ, 0, 3, 0, 0);
      add_entry(5, OP_WR, 16'h1000, 2, 0, 0);         // External source only
      add_entry(5, OP_EXT, 0, 0, 0, 0);
      add_entry(5, OP_IRQ, 0, 4, 0, 1);
      add_entry(5, OP_RD, 16'h1004, 0, 0, 2);
      add_entry(5, OP_WR, 16'h1004, 2, 0, 0);
      add_entry(5, OP_IRQ, 0, 3, 0, 0);
      add_entry(5, OP_RD, 16'h1004, 0, 0, 0);
      add_entry(5, OP_WR, 16'h1000, 0, 0, 0);
      add_entry(5, OP_EXT, 0, 0, 0, 0);
      add_entry(5, OP_IDLE, 0, 6, 0, 0);
      add_entry(5, OP_IRQ, 0, 1, 0, 0);               // Stays low while disabled
      add_entry(6, OP_WR, 16'h2000, rnd[4] | 1, 0, 0);
      add_entry(6, OP_RST, 0, 2, 0, 0);
      add_entry(6, OP_RD, 16'h2000, 0, 0, 1);         // Only bit 0 stored
      add_entry(6, OP_WR, 16'h2000, rnd[4] & ~32'd1, 0, 0);
      add_entry(6, OP_RST, 0, 3, 0, 1);
      add_entry(6, OP_RD, 16'h2000, 0, 0, 0);
      repeat (3) @(posedge clk_i);
      arst_n_i <= 1'b1;
      @(negedge clk_i);
      foreach (stim_q[i]) begin
         e = stim_q[i];
         case (e.op)
            OP_WR:    bus_access(1'b1, e.adr, e.wdat, rd);
            OP_RD: begin
               bus_access(1'b0, e.adr, e.wdat, rd);
               check_word(rd, e.exp, "read data");
            end
            OP_PINS: begin
               @(posedge clk_i);
               gpio_in_i <= e.pins;
               repeat (4) @(negedge clk_i);           // Synchronizer plus input register
            end
            OP_EXT: begin
               @(posedge clk_i);
               irq_ext_i <= 1'b1;
               repeat (2) @(posedge clk_i);
               irq_ext_i <= 1'b0;
               @(negedge clk_i);
            end
            OP_IDLE:  repeat (e.wdat) @(negedge clk_i);
            OP_PORTS: begin
               check_pins(gpio_out_o, e.exp[15:0], "gpio outputs");
               check_pins(gpio_oe_o, e.exp[31:16], "gpio output enables");
               check_flag(wb_rsp_o.ack, 1'b0, "idle ack");
            end
            default: begin
               n = 0;
               while (n < e.wdat &&
                      (e.op == OP_IRQ ? cpu_irq_o : cpu_rst_n_o) !== e.exp[0]) begin
                  @(negedge clk_i);
                  n++;
               end
               if (e.op == OP_IRQ)
                  check_flag(cpu_irq_o, e.exp[0], "cpu interrupt");
               else
                  check_flag(cpu_rst_n_o, e.exp[0], "cpu reset");
            end
         endcase
         if (i == stim_q.size() - 1 || stim_q[i + 1].test != e.test) begin
            tests++;
            $display("test %0d finished with %0d errors", e.test, errors - errs_at);
            errs_at = errors;
         end
      end
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

/* nanorv32_periph.f */
+incdir+.
nanorv32_pkg.sv
periph_decode.sv
gpio_regs.sv
nanorv32_intc.sv
cpuctrl.sv
nanorv32_periph.sv
tb_nanorv32_periph.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_nanorv32_periph \
      -f nanorv32_periph.f -o tb_sim; then
   echo "verilator build failed"
   exit 1
fi

if ! ./obj_dir/tb_sim > sim.log 2>&1; then
   cat sim.log
   echo "simulation exited with an error"
   exit 1
fi

cat sim.log
if grep -q "Errors found" sim.log; then
   exit 1
fi
exit 0
